// File: logic/fv_bank_pkg.sv
// **************************************************
// default sizes assume powers of two for banks, nodes, lines and PEs
// **************************************************
package fv_bank_pkg;

    // geometry defaults, the top passes these down as parameters
    parameter int DEF_NUM_BANKS      = 4;
    parameter int DEF_NODES_PER_BANK = 16;
    parameter int DEF_FV_LINES       = 8;   // lines per node feature vector
    parameter int DEF_LINE_W         = 64;
    parameter int DEF_NUM_PE         = 4;   // sets the tag width

    // request opcode
    typedef enum logic {
        FV_OP_READ  = 1'b0,
        FV_OP_WRITE = 1'b1
    } fv_op_e;

    // bank controller FSM
    typedef enum logic [1:0] {
        CNTL_IDLE     = 2'd0,
        CNTL_WRITE    = 2'd1,
        CNTL_RD_FETCH = 2'd2,   // one SRAM read per line
        CNTL_RD_SEND  = 2'd3    // line offered on the read stream
    } fv_cntl_state_e;

endpackage

// File: logic/fv_bank_if.sv
// **************************************************
// fields of fv_req_if hold still while req or ack is high
// **************************************************

// four-phase request, router to one bank controller
interface fv_req_if #(
    parameter int ROW_W  = 4,
    parameter int IDX_W  = 3,
    parameter int LINE_W = 64,
    parameter int TAG_W  = 2
);
    import fv_bank_pkg::*;

    logic              req;
    logic              ack;
    fv_op_e            op;
    logic [ROW_W-1:0]  node_row;   // node id without the bank bits
    logic [IDX_W-1:0]  line_idx;   // write only
    logic [LINE_W-1:0] data;
    logic [TAG_W-1:0]  pe_tag;     // read only

    modport requester (
        output req,
        output op,
        output node_row,
        output line_idx,
        output data,
        output pe_tag,
        input  ack
    );

    modport responder (
        input  req,
        input  op,
        input  node_row,
        input  line_idx,
        input  data,
        input  pe_tag,
        output ack
    );
endinterface

// read stream, one line per valid/ready transfer
interface fv_rd_if #(
    parameter int LINE_W = 64,
    parameter int TAG_W  = 2
);
    logic              valid;
    logic              ready;
    logic              sos;
    logic              eos;
    logic [LINE_W-1:0] data;
    logic [TAG_W-1:0]  pe_tag;

    modport source (output valid, output sos, output eos, output data,
                    output pe_tag, input ready);

    modport sink (input valid, input sos, input eos, input data,
                  input pe_tag, output ready);
endinterface

// File: logic/fv_req_router.sv
// **************************************************
// one request in flight at the top port, fields latched on accept
// **************************************************
module fv_req_router #(
    parameter int NUM_BANKS      = fv_bank_pkg::DEF_NUM_BANKS,
    parameter int NODES_PER_BANK = fv_bank_pkg::DEF_NODES_PER_BANK,
    parameter int FV_LINES       = fv_bank_pkg::DEF_FV_LINES,
    parameter int LINE_W         = fv_bank_pkg::DEF_LINE_W,
    parameter int NUM_PE         = fv_bank_pkg::DEF_NUM_PE
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        req,
    output logic                                        ack,
    input  fv_bank_pkg::fv_op_e                         op,
    input  logic [$clog2(NUM_BANKS*NODES_PER_BANK)-1:0] node_id,
    input  logic [$clog2(FV_LINES)-1:0]                 line_idx,
    input  logic [LINE_W-1:0]                           wr_data,
    input  logic [$clog2(NUM_PE)-1:0]                   pe_tag,
    fv_req_if.requester                                 banks [NUM_BANKS]
);
    import fv_bank_pkg::*;

    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int NODE_W = $clog2(NUM_BANKS*NODES_PER_BANK);
    localparam int ROW_W  = $clog2(NODES_PER_BANK);
    localparam int IDX_W  = $clog2(FV_LINES);
    localparam int TAG_W  = $clog2(NUM_PE);

    logic              busy;
    logic              req_q;      // req toward the selected bank
    logic [BANK_W-1:0] sel_q;
    fv_op_e            op_q;
    logic [ROW_W-1:0]  row_q;
    logic [IDX_W-1:0]  idx_q;
    logic [LINE_W-1:0] data_q;
    logic [TAG_W-1:0]  tag_q;

    logic [NUM_BANKS-1:0] bank_req;
    logic [NUM_BANKS-1:0] bank_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            req_q <= 1'b0;
            sel_q <= '0;
        end else if (!busy) begin
            if (req) begin
                busy  <= 1'b1;
                req_q <= 1'b1;
                sel_q <= node_id[BANK_W-1:0];   // low id bits pick the bank
            end
        end else begin
            if (!req) begin
                req_q <= 1'b0;
            end
            if (!req_q && !bank_ack[sel_q]) begin
                busy <= 1'b0;                   // handshake closed on the bank side
            end
        end
    end

    // payload, only loaded on accept
    always_ff @(posedge clk) begin
        if (!busy && req) begin
            op_q   <= op;
            row_q  <= node_id[NODE_W-1:BANK_W];
            idx_q  <= line_idx;
            data_q <= wr_data;
            tag_q  <= pe_tag;
        end
    end

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        assign bank_req[i]       = req_q && (sel_q == BANK_W'(i));
        assign banks[i].req      = bank_req[i];
        assign banks[i].op       = op_q;
        assign banks[i].node_row = row_q;
        assign banks[i].line_idx = idx_q;
        assign banks[i].data     = data_q;
        assign banks[i].pe_tag   = tag_q;
        assign bank_ack[i]       = banks[i].ack;
    end

    assign ack = busy && bank_ack[sel_q];   // same-cycle mirror

    a_one_bank_req : assert property (@(posedge clk) disable iff (reset)
        $onehot0(bank_req));

endmodule

// File: logic/fv_sram.sv
// **************************************************
// contents undefined after power-up, one-cycle read
// **************************************************
module fv_sram #(
    parameter int DEPTH  = 128,
    parameter int LINE_W = 64
) (
    input  logic                     clk,
    input  logic                     cen,     // active low
    input  logic                     wen,     // active low
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [LINE_W-1:0]        wdata,
    output logic [LINE_W-1:0]        rdata
);

    logic [LINE_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];   // output holds until next read
            end
        end
    end

endmodule

// File: logic/fv_bank_cntl.sv
// **************************************************
// one request at a time and FV_LINES lines per read burst
// **************************************************
module fv_bank_cntl #(
    parameter int NODES_PER_BANK = fv_bank_pkg::DEF_NODES_PER_BANK,
    parameter int FV_LINES       = fv_bank_pkg::DEF_FV_LINES,
    parameter int LINE_W         = fv_bank_pkg::DEF_LINE_W,
    parameter int NUM_PE         = fv_bank_pkg::DEF_NUM_PE
) (
    input  logic                                          clk,
    input  logic                                          reset,
    fv_req_if.responder                                   req_port,
    fv_rd_if.source                                       rd_port,
    output logic                                          cen,
    output logic                                          wen,
    output logic [$clog2(NODES_PER_BANK*FV_LINES)-1:0]    addr,
    output logic [LINE_W-1:0]                             wdata,
    input  logic [LINE_W-1:0]                             rdata
);
    import fv_bank_pkg::*;

    localparam int ROW_W = $clog2(NODES_PER_BANK);
    localparam int IDX_W = $clog2(FV_LINES);
    localparam int TAG_W = $clog2(NUM_PE);

    fv_cntl_state_e   state;
    logic             ack_q;
    logic             valid_q;
    logic [IDX_W-1:0] line_cnt;
    logic [ROW_W-1:0] row_q;
    logic [TAG_W-1:0] tag_q;
    logic             accept;
    logic             last_line;

    assign accept    = (state == CNTL_IDLE) && req_port.req && !ack_q;
    assign last_line = (line_cnt == IDX_W'(FV_LINES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= CNTL_IDLE;
            ack_q    <= 1'b0;
            valid_q  <= 1'b0;
            line_cnt <= '0;
        end else begin
            // ack may drop mid-burst so other banks can be served
            if (ack_q && !req_port.req) begin
                ack_q <= 1'b0;
            end
            case (state)
                CNTL_IDLE: begin
                    if (accept) begin
                        ack_q    <= 1'b1;
                        line_cnt <= '0;
                        state    <= (req_port.op == FV_OP_WRITE) ? CNTL_WRITE : CNTL_RD_FETCH;
                    end
                end
                CNTL_WRITE: begin
                    state <= CNTL_IDLE;   // single line written
                end
                CNTL_RD_FETCH: begin
                    valid_q <= 1'b1;
                    state   <= CNTL_RD_SEND;
                end
                CNTL_RD_SEND: begin
                    if (valid_q && rd_port.ready) begin
                        valid_q <= 1'b0;
                        if (last_line) begin
                            line_cnt <= '0;
                            state    <= CNTL_IDLE;
                        end else begin
                            line_cnt <= line_cnt + 1'b1;
                            state    <= CNTL_RD_FETCH;
                        end
                    end
                end
                default: state <= CNTL_IDLE;
            endcase
        end
    end

    // read context for the burst
    always_ff @(posedge clk) begin
        if (accept) begin
            row_q <= req_port.node_row;
            tag_q <= req_port.pe_tag;
        end
    end

    // SRAM address is the node row on top of the line index
    always_comb begin
        cen  = 1'b1;
        wen  = 1'b1;
        addr = {row_q, line_cnt};
        case (state)
            CNTL_WRITE: begin
                cen  = 1'b0;
                wen  = 1'b0;
                addr = {req_port.node_row, req_port.line_idx};
            end
            CNTL_RD_FETCH: cen = 1'b0;
            default: ;
        endcase
    end

    assign wdata = req_port.data;
    assign req_port.ack = ack_q;

    // registered SRAM read doubles as the line register and holds while cen is high
    assign rd_port.valid  = valid_q;
    assign rd_port.data   = rdata;
    assign rd_port.sos    = (line_cnt == '0);
    assign rd_port.eos    = last_line;
    assign rd_port.pe_tag = tag_q;

    a_ack_needs_req : assert property (@(posedge clk) disable iff (reset)
        $rose(ack_q) |-> req_port.req);

    a_hold_line : assert property (@(posedge clk) disable iff (reset)
        valid_q && !rd_port.ready |=> valid_q && $stable(rd_port.data)
                                      && $stable(rd_port.eos));

endmodule

// File: logic/fv_rd_merge.sv
// **************************************************
// whole bursts only, one idle cycle between grants
// **************************************************
module fv_rd_merge #(
    parameter int NUM_BANKS = fv_bank_pkg::DEF_NUM_BANKS,
    parameter int LINE_W    = fv_bank_pkg::DEF_LINE_W,
    parameter int NUM_PE    = fv_bank_pkg::DEF_NUM_PE
) (
    input  logic                      clk,
    input  logic                      reset,
    fv_rd_if.sink                     srcs [NUM_BANKS],
    output logic                      rd_valid,
    input  logic                      rd_ready,
    output logic                      rd_sos,
    output logic                      rd_eos,
    output logic [LINE_W-1:0]         rd_data,
    output logic [$clog2(NUM_PE)-1:0] rd_pe_tag
);

    localparam int SEL_W = $clog2(NUM_BANKS);
    localparam int TAG_W = $clog2(NUM_PE);

    logic [NUM_BANKS-1:0] src_valid;
    logic [NUM_BANKS-1:0] src_sos;
    logic [NUM_BANKS-1:0] src_eos;
    logic [LINE_W-1:0]    src_data [NUM_BANKS];
    logic [TAG_W-1:0]     src_tag  [NUM_BANKS];

    logic             busy;
    logic [SEL_W-1:0] grant_q;   // also the last granted bank
    logic [SEL_W-1:0] pick;
    logic             found;

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_src
        assign src_valid[i] = srcs[i].valid;
        assign src_sos[i]   = srcs[i].sos;
        assign src_eos[i]   = srcs[i].eos;
        assign src_data[i]  = srcs[i].data;
        assign src_tag[i]   = srcs[i].pe_tag;
        assign srcs[i].ready = busy && (grant_q == SEL_W'(i)) && rd_ready;
    end

    // round-robin, search starts after the last grant
    always_comb begin
        pick  = grant_q;
        found = 1'b0;
        for (int k = 1; k <= NUM_BANKS; k++) begin
            int idx;
            idx = (int'(grant_q) + k) % NUM_BANKS;
            if (!found && src_valid[idx]) begin
                pick  = SEL_W'(idx);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            grant_q <= SEL_W'(NUM_BANKS - 1);   // bank 0 first
        end else if (!busy) begin
            if (found) begin
                busy    <= 1'b1;
                grant_q <= pick;
            end
        end else if (rd_valid && rd_ready && rd_eos) begin
            busy <= 1'b0;
        end
    end

    assign rd_valid  = busy && src_valid[grant_q];
    assign rd_sos    = src_sos[grant_q];
    assign rd_eos    = src_eos[grant_q];
    assign rd_data   = src_data[grant_q];
    assign rd_pe_tag = src_tag[grant_q];

    a_grant_held : assert property (@(posedge clk) disable iff (reset)
        busy |=> $stable(grant_q));

endmodule

// File: logic/fv_bank_top.sv
// **************************************************
// node id low bits select the bank, one request at a time at the port
// **************************************************
module fv_bank_top #(
    parameter int NUM_BANKS      = fv_bank_pkg::DEF_NUM_BANKS,
    parameter int NODES_PER_BANK = fv_bank_pkg::DEF_NODES_PER_BANK,
    parameter int FV_LINES       = fv_bank_pkg::DEF_FV_LINES,
    parameter int LINE_W         = fv_bank_pkg::DEF_LINE_W,
    parameter int NUM_PE         = fv_bank_pkg::DEF_NUM_PE
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        req,
    output logic                                        ack,
    input  fv_bank_pkg::fv_op_e                         op,
    input  logic [$clog2(NUM_BANKS*NODES_PER_BANK)-1:0] node_id,
    input  logic [$clog2(FV_LINES)-1:0]                 line_idx,
    input  logic [LINE_W-1:0]                           wr_data,
    input  logic [$clog2(NUM_PE)-1:0]                   pe_tag,
    output logic                                        rd_valid,
    input  logic                                        rd_ready,
    output logic                                        rd_sos,
    output logic                                        rd_eos,
    output logic [LINE_W-1:0]                           rd_data,
    output logic [$clog2(NUM_PE)-1:0]                   rd_pe_tag
);

    localparam int ROW_W  = $clog2(NODES_PER_BANK);
    localparam int IDX_W  = $clog2(FV_LINES);
    localparam int TAG_W  = $clog2(NUM_PE);
    localparam int DEPTH  = NODES_PER_BANK * FV_LINES;
    localparam int ADDR_W = $clog2(DEPTH);

    fv_req_if #(.ROW_W(ROW_W), .IDX_W(IDX_W), .LINE_W(LINE_W), .TAG_W(TAG_W))
        req_bus [NUM_BANKS] ();
    fv_rd_if #(.LINE_W(LINE_W), .TAG_W(TAG_W)) rd_bus [NUM_BANKS] ();

    fv_req_router #(
        .NUM_BANKS      (NUM_BANKS),
        .NODES_PER_BANK (NODES_PER_BANK),
        .FV_LINES       (FV_LINES),
        .LINE_W         (LINE_W),
        .NUM_PE         (NUM_PE)
    ) fv_req_router_inst (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .ack      (ack),
        .op       (op),
        .node_id  (node_id),
        .line_idx (line_idx),
        .wr_data  (wr_data),
        .pe_tag   (pe_tag),
        .banks    (req_bus)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        logic              cen;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] wdata;
        logic [LINE_W-1:0] rdata;

        fv_bank_cntl #(
            .NODES_PER_BANK (NODES_PER_BANK),
            .FV_LINES       (FV_LINES),
            .LINE_W         (LINE_W),
            .NUM_PE         (NUM_PE)
        ) fv_bank_cntl_inst (
            .clk      (clk),
            .reset    (reset),
            .req_port (req_bus[i]),
            .rd_port  (rd_bus[i]),
            .cen      (cen),
            .wen      (wen),
            .addr     (addr),
            .wdata    (wdata),
            .rdata    (rdata)
        );

        fv_sram #(.DEPTH(DEPTH), .LINE_W(LINE_W)) fv_sram_inst (
            .clk   (clk),
            .cen   (cen),
            .wen   (wen),
            .addr  (addr),
            .wdata (wdata),
            .rdata (rdata)
        );
    end

    fv_rd_merge #(
        .NUM_BANKS (NUM_BANKS),
        .LINE_W    (LINE_W),
        .NUM_PE    (NUM_PE)
    ) fv_rd_merge_inst (
        .clk       (clk),
        .reset     (reset),
        .srcs      (rd_bus),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_sos    (rd_sos),
        .rd_eos    (rd_eos),
        .rd_data   (rd_data),
        .rd_pe_tag (rd_pe_tag)
    );

endmodule

// File: bench/fv_bank_tb.sv
// **************************************************
// default sizes only, stimulus from a fixed LCG seed
// **************************************************
module fv_bank_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import fv_bank_pkg::*;

    localparam int NUM_BANKS      = DEF_NUM_BANKS;
    localparam int NODES_PER_BANK = DEF_NODES_PER_BANK;
    localparam int FV_LINES       = DEF_FV_LINES;
    localparam int LINE_W         = DEF_LINE_W;
    localparam int NUM_PE         = DEF_NUM_PE;
    localparam int NUM_NODES      = NUM_BANKS * NODES_PER_BANK;
    localparam int NODE_W         = $clog2(NUM_NODES);
    localparam int IDX_W          = $clog2(FV_LINES);
    localparam int TAG_W          = $clog2(NUM_PE);
    localparam logic [31:0] SEED  = 32'd50087;
    localparam int NUM_WR_NODES   = 12;
    localparam int NUM_READS      = 12;
    localparam int TIMEOUT        = 40 * (NUM_WR_NODES + NUM_READS) * FV_LINES + 200;

    logic              clk;
    logic              reset    = 1'b1;
    logic              req      = 1'b0;
    logic              ack;
    fv_op_e            op       = FV_OP_READ;
    logic [NODE_W-1:0] node_id  = '0;
    logic [IDX_W-1:0]  line_idx = '0;
    logic [LINE_W-1:0] wr_data  = '0;
    logic [TAG_W-1:0]  pe_tag   = '0;
    logic              rd_valid;
    logic              rd_ready = 1'b0;
    logic              rd_sos;
    logic              rd_eos;
    logic [LINE_W-1:0] rd_data;
    logic [TAG_W-1:0]  rd_pe_tag;

    logic [LINE_W-1:0]    shadow [NUM_NODES*FV_LINES];   // node * FV_LINES + line
    logic [NODE_W-1:0]    tag_node [NUM_PE];
    logic [IDX_W-1:0]     beat_cnt [NUM_PE];
    logic [NUM_PE-1:0]    tag_busy    = '0;
    logic                 in_burst    = 1'b0;
    logic [TAG_W-1:0]     burst_tag;
    logic                 stalled_q   = 1'b0;
    logic [LINE_W-1:0]    held_data;
    logic [TAG_W+1:0]     held_ctl;
    logic                 reset_q     = 1'b1;
    logic                 reset_seen  = 1'b0;
    logic                 stall_seen  = 1'b0;
    logic [NUM_BANKS-1:0] in_send;
    int                   bursts_done = 0;
    int                   cycle_cnt   = 0;
    logic [31:0]          stim_state  = SEED;
    logic [31:0]          ready_state = SEED;

    fv_bank_top #(
        .NUM_BANKS      (NUM_BANKS),
        .NODES_PER_BANK (NODES_PER_BANK),
        .FV_LINES       (FV_LINES),
        .LINE_W         (LINE_W),
        .NUM_PE         (NUM_PE)
    ) fv_bank_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        stim_state = lcg_next(stim_state);
        r = stim_state;
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [LINE_W-1:0] expected,
                                   input logic [LINE_W-1:0] actual);
        stop_on_error($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                name, expected, actual));
    endtask

    // one four-phase request, returns once ack is low again
    task automatic send_request(input fv_op_e kind, input logic [NODE_W-1:0] node,
                                input logic [IDX_W-1:0] line, input logic [LINE_W-1:0] data,
                                input logic [TAG_W-1:0] tag);
        op       <= kind;
        node_id  <= node;
        line_idx <= line;
        wr_data  <= data;
        pe_tag   <= tag;
        req      <= 1'b1;
        @(posedge clk);
        while (!ack) @(posedge clk);
        if (kind == FV_OP_WRITE) begin
            shadow[int'(node) * FV_LINES + int'(line)] = data;
        end
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
    endtask

    initial begin : stimulus
        logic [31:0]       r;
        logic [LINE_W-1:0] line_data;
        logic [NODE_W-1:0] node_list [NUM_WR_NODES];
        logic [NODE_W-1:0] node;
        int                tag;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < NUM_WR_NODES; n++) begin
            draw_random(r);
            node_list[n] = NODE_W'(r[31:16] % NUM_NODES);
            for (int l = 0; l < FV_LINES; l++) begin
                for (int w = 0; w < LINE_W; w += 16) begin
                    draw_random(r);
                    line_data[w +: 16] = r[31:16];
                end
                send_request(FV_OP_WRITE, node_list[n], IDX_W'(l), line_data, '0);
            end
        end
        for (int i = 0; i < NUM_READS; i++) begin
            draw_random(r);
            node = node_list[r[31:16] % NUM_WR_NODES];
            tag = -1;
            while (tag < 0) begin
                for (int t = 0; t < NUM_PE; t++) begin
                    if (tag < 0 && !tag_busy[t]) tag = t;
                end
                if (tag < 0) @(posedge clk);   // all tags out, wait for an eos
            end
            tag_busy[tag] = 1'b1;
            tag_node[tag] = node;
            beat_cnt[tag] = '0;
            send_request(FV_OP_READ, node, '0, '0, TAG_W'(tag));
        end
        while (tag_busy != '0) @(posedge clk);
        @(posedge clk);
        if (bursts_done != NUM_READS) begin
            report_mismatch("burst count", NUM_READS, bursts_done);
        end else if (!stall_seen) begin
            stop_on_error("no bank waited in CNTL_RD_SEND under back-pressure");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    always @(posedge clk) begin
        ready_state <= lcg_next(ready_state);
        rd_ready    <= (ready_state[31:30] != 2'b00);   // low about one cycle in four
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            stop_on_error($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT));
        end
        reset_q <= reset;
        if (reset) reset_seen <= 1'b1;
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_state
        assign in_send[b] = (fv_bank_top_inst.g_bank[b].fv_bank_cntl_inst.state == CNTL_RD_SEND);
    end

    always @(posedge clk) begin : read_monitor
        logic [IDX_W-1:0]  beat;
        logic [LINE_W-1:0] expected;
        if (!reset) begin
            if (stalled_q) begin
                assert (rd_valid) else stop_on_error("rd_valid dropped while stalled");
                assert (rd_data == held_data)
                    else report_mismatch("stall data", held_data, rd_data);
                assert ({rd_sos, rd_eos, rd_pe_tag} == held_ctl)
                    else report_mismatch("stall sos/eos/tag", held_ctl, {rd_sos, rd_eos, rd_pe_tag});
            end
            if (rd_valid && rd_ready) begin
                assert (tag_busy[rd_pe_tag])
                    else stop_on_error("read line arrived for a tag with no read outstanding");
                if (in_burst) begin
                    assert (rd_pe_tag == burst_tag)
                        else report_mismatch("burst tag", burst_tag, rd_pe_tag);
                end
                beat     = beat_cnt[rd_pe_tag];
                expected = shadow[int'(tag_node[rd_pe_tag]) * FV_LINES + int'(beat)];
                assert (rd_data == expected) else report_mismatch("read data", expected, rd_data);
                assert (rd_sos == (beat == '0)) else report_mismatch("sos", beat == '0, rd_sos);
                assert (rd_eos == (beat == IDX_W'(FV_LINES - 1)))
                    else report_mismatch("eos", beat == IDX_W'(FV_LINES - 1), rd_eos);
                if (rd_eos) begin
                    tag_busy[rd_pe_tag] <= 1'b0;
                    beat_cnt[rd_pe_tag] <= '0;
                    in_burst            <= 1'b0;
                    bursts_done         <= bursts_done + 1;
                end else begin
                    beat_cnt[rd_pe_tag] <= beat + 1'b1;
                    in_burst            <= 1'b1;
                    burst_tag           <= rd_pe_tag;
                end
            end
            if ((|in_send) && rd_valid && !rd_ready) stall_seen <= 1'b1;
            stalled_q <= rd_valid && !rd_ready;
            held_data <= rd_data;
            held_ctl  <= {rd_sos, rd_eos, rd_pe_tag};
        end
    end

    // first clock edge skipped, flops are still unknown before it
    a_reset_quiet : assert property (@(posedge clk)
        reset_seen && (reset || reset_q) |-> !ack && !rd_valid)
        else report_mismatch("reset ack/rd_valid", 0, {$sampled(ack), $sampled(rd_valid)});

    a_ack_needs_req : assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> req)
        else stop_on_error("ack rose while req was low");

    a_ack_after_req : assert property (@(posedge clk) disable iff (reset)
        $fell(ack) |-> !$past(req))
        else stop_on_error("ack fell before req had fallen");

endmodule

// File: flist.f
logic/fv_bank_pkg.sv
logic/fv_bank_if.sv
logic/fv_req_router.sv
logic/fv_sram.sv
logic/fv_bank_cntl.sv
logic/fv_rd_merge.sv
logic/fv_bank_top.sv
bench/fv_bank_tb.sv

// File: Bender.yml
package:
  name: fv_bank

sources:
  - logic/fv_bank_pkg.sv
  - logic/fv_bank_if.sv
  - logic/fv_req_router.sv
  - logic/fv_sram.sv
  - logic/fv_bank_cntl.sv
  - logic/fv_rd_merge.sv
  - logic/fv_bank_top.sv
  - target: test
    files:
      - bench/fv_bank_tb.sv
